// ==== flist.f ====
common/router_pkg.sv
hw/serial_rx.sv
hw/rx_arbiter.sv
hw/item_fifo.sv
hw/tx_dispatch.sv
hw/serial_tx.sv
hw/activity_monitor.sv
hw/router.sv
testbench/router_asserts.sv
testbench/router_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module router_tb -f flist.f -o router_sim
out=$(./obj_dir/router_sim 2>&1) || true
echo "$out"
echo "$out" | grep -qx "NO ERRORS"

// ==== testbench/router_tb.sv ====
module router_tb
	import router_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int PER_PORT = 6;
	// items over all tests, sizes the watchdog
	localparam int TOTAL_ITEMS = NUM_PORTS + NUM_PORTS * PER_PORT + 7 + 8 + 1;
	localparam int TIMEOUT_CYCLES = 10 + TOTAL_ITEMS * 40 + 400;

	logic clk = 1'b0;
	logic reset;
	port_mask_t rx_data;
	port_mask_t rx_busy;
	port_mask_t tx_data;
	port_mask_t tx_busy;
	node_addr_t table_addr;
	dir_t table_data;
	activity_t activity_level;

	integer seed;
	int checks;
	int errors;
	item_t stim [NUM_PORTS][PER_PORT];
	// expected items per input and output pair, index src * NUM_PORTS + dst
	item_t exp_q [NUM_PORTS*NUM_PORTS][$];
	item_t rcv_q [NUM_PORTS][$];

	always #50 clk = ~clk;

	router router_inst (
		.clk(clk), .reset(reset), .rx_data(rx_data), .rx_busy(rx_busy),
		.tx_data(tx_data), .tx_busy(tx_busy), .table_addr(table_addr),
		.table_data(table_data), .activity_level(activity_level)
	);

	// routing table model, address modulo 8
	assign table_data = dir_t'(table_addr % 8);

	// output port for an item, -1 when the table drops it
	function automatic int expected_port(input item_t item);
		int dir;
		dir = int'(item[ITEM_BITS-1 -: ADDR_BITS]) % 8;
		if (dir < NUM_PORTS)
			return dir;
		return -1;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// ------------------------------
	// link side helpers
	// ------------------------------
	task automatic send_item(input int p, input item_t item);
		int dst;
		@(negedge clk);
		while (rx_busy[p])
			@(negedge clk);
		dst = expected_port(item);
		if (dst >= 0)
			exp_q[p*NUM_PORTS + dst].push_back(item);
		// start bit, then lsb first
		@(posedge clk);
		rx_data[p] <= 1'b1;
		for (int b = 0; b < ITEM_BITS; b++)
		begin
			@(posedge clk);
			rx_data[p] <= item[b];
		end
		@(posedge clk);
		rx_data[p] <= 1'b0;
	endtask

	task automatic send_stream(input int p);
		for (int k = 0; k < PER_PORT; k++)
			send_item(p, stim[p][k]);
	endtask

	task automatic capture_frames(input int p);
		item_t item;
		forever
		begin
			@(negedge clk);
			if (tx_data[p])
			begin
				for (int b = 0; b < ITEM_BITS; b++)
				begin
					@(negedge clk);
					item[b] = tx_data[p];
				end
				rcv_q[p].push_back(item);
			end
		end
	endtask

	task automatic wait_delivered();
		int left;
		do
		begin
			@(negedge clk);
			left = 0;
			for (int i = 0; i < NUM_PORTS*NUM_PORTS; i++)
				left += exp_q[i].size();
		end
		while (left != 0);
	endtask

	task automatic wait_drained();
		wait_delivered();
		// quiet time, late duplicates show up here
		repeat (30) @(negedge clk);
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("test %s: %0d errors", name, errors - errs_before);
	endtask

	// ------------------------------
	// compare, head of some input's queue for that output
	// ------------------------------
	initial
	begin
		item_t got;
		bit found;
		int idx;
		forever
		begin
			@(negedge clk);
			for (int p = 0; p < NUM_PORTS; p++)
			begin
				while (rcv_q[p].size() > 0)
				begin
					got = rcv_q[p].pop_front();
					found = 1'b0;
					for (int s = 0; s < NUM_PORTS; s++)
					begin
						idx = s * NUM_PORTS + p;
						if (!found && exp_q[idx].size() > 0 && exp_q[idx][0] == got)
						begin
							found = 1'b1;
							void'(exp_q[idx].pop_front());
						end
					end
					check_value(32'(found), 32'd1,
						$sformatf("item %0h not expected on output %0d", got, p));
				end
			end
		end
	end

	initial
	begin
		int mark;
		int cycles;
		node_addr_t addr;
		seed = 32'hf475;
		checks = 0;
		errors = 0;
		reset = 1'b1;
		rx_data = '0;
		tx_busy = '0;
		fork
			capture_frames(0);
			capture_frames(1);
			capture_frames(2);
			capture_frames(3);
			capture_frames(4);
		join_none
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		mark = errors;
		@(negedge clk);
		check_value(32'(tx_data), 32'd0, "tx_data after reset");
		check_value(32'(rx_busy), 32'd0, "rx_busy after reset");
		check_value(32'(activity_level), 32'd0, "activity_level after reset");
		report_test("1 reset values", mark);

		// odd inputs use the upper half of the address space
		mark = errors;
		for (int i = 0; i < NUM_PORTS; i++)
		begin
			send_item(i, item_t'({4'((i + 2) % NUM_PORTS + 8 * (i % 2)), 4'(i + 9)}));
			wait_drained();
		end
		report_test("2 single items", mark);

		mark = errors;
		for (int p = 0; p < NUM_PORTS; p++)
			for (int k = 0; k < PER_PORT; k++)
				stim[p][k] = item_t'($random(seed));
		fork
			send_stream(0);
			send_stream(1);
			send_stream(2);
			send_stream(3);
			send_stream(4);
		join
		wait_drained();
		report_test("3 random traffic", mark);

		// east held busy, queue fills and input 0 stalls
		mark = errors;
		@(posedge clk);
		tx_busy[2] <= 1'b1;
		fork
			for (int k = 0; k < 7; k++)
				send_item(0, item_t'({4'd2, 4'(k)}));
			begin
				repeat (120) @(negedge clk);
				check_value(32'(rx_busy[0]), 32'd1, "rx_busy under back-pressure");
				check_value(32'(exp_q[2].size()), 32'd6, "items waiting for east");
				@(posedge clk);
				tx_busy[2] <= 1'b0;
			end
		join
		wait_drained();
		report_test("4 back-pressure", mark);

		// even k dropped by the table, odd k delivered
		mark = errors;
		for (int k = 0; k < 8; k++)
		begin
			if (k % 2 == 0)
				addr = 4'(k / 2 % 3 + 5 + 8 * (k / 6));
			else
				addr = 4'(k % NUM_PORTS);
			send_item(3, item_t'({addr, 4'(k + 3)}));
		end
		wait_drained();
		report_test("5 discarded items", mark);

		mark = errors;
		send_item(1, item_t'({4'd4, 4'hc}));
		cycles = 0;
		while (activity_level == '0 && cycles < 60)
		begin
			@(negedge clk);
			cycles++;
		end
		check_value(32'(activity_level != '0), 32'd1, "activity_level while sending");
		// idle time counts from the end of the frame
		wait_delivered();
		repeat (HOLD_CYCLES + 3) @(negedge clk);
		check_value(32'(activity_level), 32'd0, "activity_level after idle");
		report_test("6 activity level", mark);

		$display("tests done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("watchdog: traffic did not drain within %0d cycles", TIMEOUT_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== testbench/router_asserts.sv ====
module router_asserts
	import router_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input logic       write,
	input logic       read,
	input logic       full,
	input logic       empty,
	input port_mask_t req
);

	timeunit 1ns;
	timeprecision 1ns;

	// ------------------------------
	// queue boundaries
	// ------------------------------
	no_write_full: assert property (@(posedge clk) disable iff (reset) !(write && full))
		else $error("queue written while full");

	no_read_empty: assert property (@(posedge clk) disable iff (reset) !(read && empty))
		else $error("queue read while empty");

	// dispatch starts one transmitter at most
	one_req: assert property (@(posedge clk) disable iff (reset) $onehot0(req))
		else $error("more than one transmit request");

endmodule

// queue and dispatch nets meet in the top level
bind router router_asserts asserts_inst (
	.clk(clk), .reset(reset), .write(write), .read(read),
	.full(full), .empty(empty), .req(tx_req)
);

// ==== hw/router.sv ====
module router
	import router_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  port_mask_t rx_data,
	output port_mask_t rx_busy,
	output port_mask_t tx_data,
	input  port_mask_t tx_busy,
	output node_addr_t table_addr,
	input  dir_t       table_data,
	output activity_t  activity_level
);

	// receive side
	port_mask_t rx_valid;
	port_mask_t rx_read;
	item_t rx_item [NUM_PORTS];

	// queue interface
	item_t arb_item;
	item_t head_item;
	logic write;
	logic read;
	logic full;
	logic empty;

	// transmit side
	port_mask_t tx_req;
	port_mask_t ser_busy;
	port_mask_t tx_active;

	// ------------------------------
	// receivers, one per link
	// ------------------------------
	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_rx
		serial_rx rx_inst (
			.clk(clk), .reset(reset),
			.serial_in(rx_data[p]), .item_read(rx_read[p]),
			.channel_busy(rx_busy[p]), .valid(rx_valid[p]),
			.parallel_out(rx_item[p])
		);
	end

	rx_arbiter arb_inst (
		.clk(clk), .reset(reset), .valid(rx_valid),
		.item_n(rx_item[0]), .item_s(rx_item[1]), .item_e(rx_item[2]),
		.item_w(rx_item[3]), .item_l(rx_item[4]),
		.full(full), .item_read(rx_read), .write(write), .item_out(arb_item)
	);

	item_fifo fifo_inst (
		.clk(clk), .reset(reset), .write(write), .read(read),
		.item_in(arb_item), .item_out(head_item), .full(full), .empty(empty)
	);

	tx_dispatch dispatch_inst (
		.item_in(head_item), .empty(empty),
		.table_addr(table_addr), .table_data(table_data),
		.tx_busy(ser_busy), .req(tx_req), .read(read)
	);

	// ------------------------------
	// transmitters share the head item
	// ------------------------------
	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_tx
		serial_tx tx_inst (
			.clk(clk), .reset(reset),
			.req(tx_req[p]), .parallel_in(head_item),
			.channel_busy(tx_busy[p]), .tx_busy(ser_busy[p]),
			.tx_active(tx_active[p]), .serial_out(tx_data[p])
		);
	end

	activity_monitor monitor_inst (
		.clk(clk), .reset(reset),
		.tx_active(tx_active), .activity_level(activity_level)
	);

endmodule

// ==== hw/activity_monitor.sv ====
module activity_monitor
	import router_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  port_mask_t tx_active,
	output activity_t  activity_level
);

	logic [1:0] hold [NUM_PORTS];
	activity_t active_count;

	// ------------------------------
	// per-port hold counters
	// ------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_PORTS; i++)
				hold[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < NUM_PORTS; i++)
			begin
				// reload while shifting, else drain to zero
				if (tx_active[i])
					hold[i] <= 2'(HOLD_CYCLES);
				else if (hold[i] != '0)
					hold[i] <= hold[i] - 2'd1;
			end
		end
	end

	// count ports still inside their hold window
	always_comb
	begin
		active_count = '0;
		for (int i = 0; i < NUM_PORTS; i++)
			active_count = active_count + activity_t'(hold[i] != '0);
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			activity_level <= '0;
		else
			activity_level <= active_count;
	end

endmodule

// ==== hw/serial_tx.sv ====
module serial_tx
	import router_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  req,
	input  item_t parallel_in,
	input  logic  channel_busy,
	output logic  tx_busy,
	output logic  tx_active,
	output logic  serial_out
);

	tx_state_t state;
	// item latched, waiting or shifting
	logic pending;
	logic [3:0] bit_cnt;
	// start bit sits in bit 0
	logic [FRAME_BITS-1:0] shift_reg;

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= TX_IDLE;
			pending <= 1'b0;
			bit_cnt <= '0;
		end
		else
		begin
			case (state)
				TX_IDLE:
				begin
					if (!pending)
						pending <= req;
					// hold the item until downstream is free
					else if (!channel_busy)
					begin
						state <= TX_SHIFT;
						bit_cnt <= '0;
					end
				end
				TX_SHIFT:
				begin
					bit_cnt <= bit_cnt + 4'd1;
					if (bit_cnt == 4'(FRAME_BITS - 1))
					begin
						state <= TX_IDLE;
						pending <= 1'b0;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// payload shifter, lsb first after the start bit
	always_ff @(posedge clk)
	begin
		if (state == TX_IDLE && !pending && req)
			shift_reg <= {parallel_in, 1'b1};
		else if (state == TX_SHIFT)
			shift_reg <= {1'b0, shift_reg[FRAME_BITS-1:1]};
	end

	assign tx_busy = pending;
	assign tx_active = (state == TX_SHIFT);
	// line idles low outside a frame
	assign serial_out = tx_active && shift_reg[0];

endmodule

// ==== hw/tx_dispatch.sv ====
module tx_dispatch
	import router_pkg::*;
(
	input  item_t      item_in,
	input  logic       empty,
	output node_addr_t table_addr,
	input  dir_t       table_data,
	input  port_mask_t tx_busy,
	output port_mask_t req,
	output logic       read
);

	// destination is the upper nibble of the head item
	assign table_addr = item_in[ITEM_BITS-1 -: ADDR_BITS];

	// ------------------------------
	// route decision for queue head
	// ------------------------------
	always_comb
	begin
		req = '0;
		read = 1'b0;
		if (!empty)
		begin
			case (table_data)
				DIR_NORTH, DIR_SOUTH, DIR_EAST, DIR_WEST, DIR_LOCAL:
				begin
					// busy target stalls the head in place
					if (!tx_busy[table_data])
					begin
						req[table_data] = 1'b1;
						read = 1'b1;
					end
				end
				default:
				begin
					// no such direction, drop the item
					read = 1'b1;
				end
			endcase
		end
	end

endmodule

// ==== hw/item_fifo.sv ====
module item_fifo
	import router_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  write,
	input  logic  read,
	input  item_t item_in,
	output item_t item_out,
	output logic  full,
	output logic  empty
);

	item_t mem [FIFO_DEPTH];
	logic [FIFO_PTR_BITS-1:0] wr_ptr;
	logic [FIFO_PTR_BITS-1:0] rd_ptr;
	// occupancy, 0..FIFO_DEPTH
	logic [FIFO_CNT_BITS-1:0] count;
	logic do_write;
	logic do_read;

	assign full = (count == FIFO_CNT_BITS'(FIFO_DEPTH));
	assign empty = (count == '0);

	// guard against overflow and underflow
	assign do_write = write && !full;
	assign do_read = read && !empty;

	// ------------------------------
	// storage
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (do_write)
			mem[wr_ptr] <= item_in;
	end

	// head visible without a read
	assign item_out = mem[rd_ptr];

	// ------------------------------
	// pointers and count
	// ------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// depth is a power of two, pointers wrap naturally
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous read and write keep the count
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== hw/rx_arbiter.sv ====
module rx_arbiter
	import router_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  port_mask_t valid,
	input  item_t      item_n,
	input  item_t      item_s,
	input  item_t      item_e,
	input  item_t      item_w,
	input  item_t      item_l,
	input  logic       full,
	output port_mask_t item_read,
	output logic       write,
	output item_t      item_out
);

	item_t items [NUM_PORTS];
	// port granted last, search starts after it
	logic [2:0] last_grant;
	logic [2:0] sel;
	logic [2:0] cand;
	logic found;

	assign items[0] = item_n;
	assign items[1] = item_s;
	assign items[2] = item_e;
	assign items[3] = item_w;
	assign items[4] = item_l;

	// ------------------------------
	// round-robin search
	// ------------------------------
	always_comb
	begin
		found = 1'b0;
		sel = last_grant;
		cand = last_grant;
		for (int i = 1; i <= NUM_PORTS; i++)
		begin
			cand = 3'((32'(last_grant) + i) % NUM_PORTS);
			if (!found && valid[cand])
			begin
				found = 1'b1;
				sel = cand;
			end
		end
	end

	// one item per cycle, only when queue has room
	assign write = found && !full;
	assign item_read = write ? port_mask_t'(1 << sel) : '0;
	assign item_out = items[sel];

	// pointer moves on a grant only
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			last_grant <= 3'(NUM_PORTS - 1);
		else if (write)
			last_grant <= sel;
	end

endmodule

// ==== hw/serial_rx.sv ====
module serial_rx
	import router_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  serial_in,
	input  logic  item_read,
	output logic  channel_busy,
	output logic  valid,
	output item_t parallel_out
);

	rx_state_t state;
	logic [2:0] bit_cnt;
	item_t shift_reg;

	// ------------------------------
	// frame FSM
	// ------------------------------
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= RX_IDLE;
			bit_cnt <= '0;
		end
		else
		begin
			case (state)
				RX_IDLE:
				begin
					// line idles low, a 1 is the start bit
					if (serial_in)
					begin
						state <= RX_SHIFT;
						bit_cnt <= '0;
					end
				end
				RX_SHIFT:
				begin
					bit_cnt <= bit_cnt + 3'd1;
					// eighth data bit ends the frame
					if (bit_cnt == 3'(ITEM_BITS - 1))
						state <= RX_HOLD;
				end
				RX_HOLD:
				begin
					// wait for the arbiter to take the item
					if (item_read)
						state <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data path, lsb arrives first
	always_ff @(posedge clk)
	begin
		if (state == RX_SHIFT)
			shift_reg <= {serial_in, shift_reg[ITEM_BITS-1:1]};
	end

	// busy from start bit until read
	assign channel_busy = (state != RX_IDLE);
	assign valid = (state == RX_HOLD);
	assign parallel_out = shift_reg;

endmodule

// ==== common/router_pkg.sv ====
package router_pkg;

	// ------------------------------
	// item layout
	// ------------------------------
	localparam int ITEM_BITS = 8;
	localparam int ADDR_BITS = 4;
	// start bit plus data bits
	localparam int FRAME_BITS = ITEM_BITS + 1;

	// routing table entry width
	localparam int DIR_BITS = 3;
	localparam int NUM_PORTS = 5;

	// queue sizing
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_BITS = FIFO_PTR_BITS + 1;

	// activity hold time, in cycles
	localparam int HOLD_CYCLES = 3;

	typedef logic [ITEM_BITS-1:0] item_t;
	typedef logic [ADDR_BITS-1:0] node_addr_t;
	typedef logic [DIR_BITS-1:0] dir_t;
	// bit 0 north, 1 south, 2 east, 3 west, 4 local
	typedef logic [NUM_PORTS-1:0] port_mask_t;
	typedef logic [2:0] activity_t;

	// ------------------------------
	// direction codes, 5..7 mean discard
	// ------------------------------
	localparam dir_t DIR_NORTH = 3'd0;
	localparam dir_t DIR_SOUTH = 3'd1;
	localparam dir_t DIR_EAST = 3'd2;
	localparam dir_t DIR_WEST = 3'd3;
	localparam dir_t DIR_LOCAL = 3'd4;

	typedef enum logic [1:0] {RX_IDLE, RX_SHIFT, RX_HOLD} rx_state_t;
	typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_t;

endpackage
